//--- sim.f
alu_pkg.sv
alu.sv
alu_regfile.sv
alu_wb_slave.sv
alu_top.sv
tb_alu_top.sv

//--- Makefile
TOP = tb_alu_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module $(TOP) -f sim.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

//--- tb_alu_top.sv
module tb_alu_top;
    timeunit 1ns;
    timeprecision 100ps;

    logic             clk;
    logic             rst_n;
    alu_pkg::wb_req_t wb_req;
    alu_pkg::wb_rsp_t wb_rsp;

    integer      seed;
    integer      errors;
    logic [31:0] model_regs [8];
    logic        model_status;
    logic [31:0] model_last;

    alu_top i_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // reference ALU, built from the opcode table
    function automatic logic [31:0] model_alu(input alu_pkg::alu_op_e op,
                                              input logic [31:0] a, input logic [31:0] b);
        case (op)
            alu_pkg::op_add: return a + b;
            alu_pkg::op_sub: return a - b;
            alu_pkg::op_and: return a & b;
            alu_pkg::op_or:  return a | b;
            alu_pkg::op_xor: return a ^ b;
            alu_pkg::op_sll: return a << b[4:0];
            alu_pkg::op_srl: return a >> b[4:0];
            default:         return 32'd0;
        endcase
    endfunction

    task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %08h got %08h", $time, name, exp, act);
        end
    endtask

    task automatic check_status(input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t status_zero expected %0b got %0b", $time, exp, act);
        end
    endtask

    // one classic single transfer, sampled at negedge where ack is stable
    task automatic bus_xfer(input logic wr, input logic [3:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
        alu_pkg::wb_req_t req;
        int               waits;
        req     = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = wr;
        req.adr = adr;
        req.dat = wdat;
        rdat    = 32'd0;
        waits   = 0;
        @(posedge clk);
        wb_req <= req;
        @(negedge clk);
        while (!wb_rsp.ack && waits < 20) begin
            @(negedge clk);
            waits++;
        end
        if (!wb_rsp.ack) begin
            errors++;
            $display("timeout: no ack within 20 cycles at address %0d", adr);
        end else begin
            rdat = wb_rsp.dat;
            if (waits != 1) begin   // ack belongs one cycle after the request
                errors++;
                $display("ack came %0d cycles after the request at address %0d, not 1",
                         waits, adr);
            end
        end
        @(posedge clk);
        wb_req <= '0;
        @(negedge clk);
        if (wb_rsp.ack) begin
            errors++;
            $display("ack stayed high for a second cycle at address %0d", adr);
        end
    endtask

    task automatic bus_write(input logic [3:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        bus_xfer(1'b1, adr, dat, unused);
    endtask

    task automatic bus_read(input logic [3:0] adr, output logic [31:0] dat);
        bus_xfer(1'b0, adr, 32'd0, dat);
    endtask

    task automatic write_reg(input alu_pkg::reg_idx_t idx, input logic [31:0] dat);
        bus_write({1'b0, idx}, dat);
        model_regs[idx] = dat;
    endtask

    task automatic check_reg(input alu_pkg::reg_idx_t idx);
        logic [31:0] got;
        bus_read({1'b0, idx}, got);
        check_data($sformatf("r%0d", idx), model_regs[idx], got);
    endtask

    task automatic check_status_reg();
        logic [31:0] got;
        bus_read(alu_pkg::adr_status, got);
        check_status(model_status, got[0]);
    endtask

    task automatic check_last();
        logic [31:0] got;
        bus_read(alu_pkg::adr_cmd, got);
        check_data("last_cmd", model_last, got);
    endtask

    task automatic check_all();
        for (int i = 0; i < 8; i++) begin
            check_reg(i[2:0]);
        end
        check_status_reg();
        check_last();
    endtask

    // issue rd = rs1 op rs2, then check rd and the flag
    task automatic run_cmd(input logic [3:0] op_val, input alu_pkg::reg_idx_t rd,
                           input alu_pkg::reg_idx_t rs1, input alu_pkg::reg_idx_t rs2);
        alu_pkg::alu_cmd_t cmd;
        logic [31:0]       res;
        logic [31:0]       fill;
        fill         = rand32();
        cmd.reserved = fill[18:0];  // stored back whole in last_cmd
        cmd.op       = alu_pkg::alu_op_e'(op_val);
        cmd.rd       = rd;
        cmd.rs1      = rs1;
        cmd.rs2      = rs2;
        res = model_alu(cmd.op, model_regs[rs1], model_regs[rs2]);
        bus_write(alu_pkg::adr_cmd, cmd);
        model_regs[rd] = res;
        model_status   = (res == 32'd0);
        model_last     = cmd;
        check_reg(rd);
        check_status_reg();
    endtask

    initial begin
        logic [31:0]       r;
        logic [31:0]       sel;
        logic [31:0]       got;
        logic [3:0]        op_val;
        alu_pkg::reg_idx_t rd;
        alu_pkg::reg_idx_t rs1;
        alu_pkg::reg_idx_t rs2;

        seed   = 9093;
        errors = 0;
        rst_n  = 1'b0;
        wb_req = '0;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = 32'd0;
        end
        model_status = 1'b0;
        model_last   = 32'd0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        check_all();    // everything cleared by reset

        for (int i = 0; i < 24; i++) begin
            r = rand32();
            write_reg(r[2:0], rand32());
            if (i % 3 == 2) begin
                check_reg(r[5:3]);
            end
        end
        check_all();

        for (int i = 0; i < 80; i++) begin
            r = rand32();
            if (i % 8 == 0) begin
                write_reg(r[2:0], rand32());    // keep operands from collapsing
            end
            r      = rand32();
            sel    = r % 32'd7;
            op_val = sel[3:0];
            rd     = r[2:0];
            rs1    = r[5:3];
            rs2    = r[8:6];
            if (i % 5 == 1) begin
                rd = rs1;
            end
            if (i % 5 == 3) begin
                rd = rs2;
            end
            // shift amount between 32 and 63
            if (op_val >= 4'd5 && r[9]) begin
                write_reg(rs2, {26'd0, 1'b1, r[14:10]});
            end
            run_cmd(op_val, rd, rs1, rs2);
            if (i % 10 == 9) begin
                check_last();
            end
        end

        // each zero result follows a nonzero one, so the flag has to move
        r = rand32();
        write_reg(3'd1, r);
        write_reg(3'd2, r);
        write_reg(3'd4, 32'hf0f0_f0f0);
        write_reg(3'd5, 32'h0f0f_0f0f);
        run_cmd(alu_pkg::op_or, 3'd6, 3'd4, 3'd5);     // nonzero clears the flag
        run_cmd(alu_pkg::op_sub, 3'd3, 3'd1, 3'd2);
        run_cmd(alu_pkg::op_or, 3'd6, 3'd4, 3'd5);
        run_cmd(alu_pkg::op_and, 3'd6, 3'd4, 3'd5);
        write_reg(3'd6, 32'd1);
        write_reg(3'd7, 32'd33);
        run_cmd(alu_pkg::op_sll, 3'd0, 3'd6, 3'd7);
        run_cmd(alu_pkg::op_srl, 3'd0, 3'd6, 3'd7);
        write_reg(3'd6, 32'h8000_0000);
        run_cmd(alu_pkg::op_srl, 3'd0, 3'd6, 3'd7);
        run_cmd(alu_pkg::op_sll, 3'd0, 3'd6, 3'd7);

        for (int k = 7; k < 16; k++) begin
            r = rand32();
            write_reg(r[2:0], rand32() | 32'h1);
            run_cmd(alu_pkg::op_or, r[2:0], r[2:0], r[2:0]);  // flag low first
            run_cmd(k[3:0], r[2:0], r[5:3], r[8:6]);
            check_last();
        end

        // unmapped addresses
        for (int adr_i = 10; adr_i < 16; adr_i++) begin
            bus_write(adr_i[3:0], rand32());
            bus_read(adr_i[3:0], got);
            check_data($sformatf("adr%0d", adr_i), 32'd0, got);
        end
        check_all();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- alu_top.sv
module alu_top (
    input  logic             clk,
    input  logic             rst_n,
    input  alu_pkg::wb_req_t wb_req,
    output alu_pkg::wb_rsp_t wb_rsp
);

    alu_pkg::reg_idx_t rd_a_idx;
    alu_pkg::reg_idx_t rd_b_idx;
    alu_pkg::reg_idx_t wr_idx;
    logic [31:0]       rd_a_data;
    logic [31:0]       rd_b_data;
    logic [31:0]       wr_data;
    logic              we;
    alu_pkg::alu_op_e  op;
    logic [31:0]       result;
    logic              zero;

    alu_wb_slave i_slave (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .rd_a_idx   (rd_a_idx),
        .rd_b_idx   (rd_b_idx),
        .rd_a_data  (rd_a_data),
        .we         (we),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .op         (op),
        .alu_result (result),
        .alu_zero   (zero)
    );

    alu_regfile i_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_a_idx  (rd_a_idx),
        .rd_b_idx  (rd_b_idx),
        .rd_a_data (rd_a_data),
        .rd_b_data (rd_b_data),
        .we        (we),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data)
    );

    // operands straight from the two read ports
    alu i_alu (
        .a      (rd_a_data),
        .b      (rd_b_data),
        .op     (op),
        .result (result),
        .zero   (zero)
    );

endmodule

//--- alu_wb_slave.sv
module alu_wb_slave (
    input  logic              clk,
    input  logic              rst_n,
    input  alu_pkg::wb_req_t  wb_req,
    output alu_pkg::wb_rsp_t  wb_rsp,
    output alu_pkg::reg_idx_t rd_a_idx,
    output alu_pkg::reg_idx_t rd_b_idx,
    input  logic [31:0]       rd_a_data,
    output logic              we,
    output alu_pkg::reg_idx_t wr_idx,
    output logic [31:0]       wr_data,
    output alu_pkg::alu_op_e  op,
    input  logic [31:0]       alu_result,
    input  logic              alu_zero
);

    alu_pkg::alu_cmd_t cmd;
    alu_pkg::alu_cmd_t last_cmd;
    logic              status_zero;

    logic        new_req;
    logic        is_reg;
    logic        is_cmd;
    logic        is_status;
    logic        cmd_wr;
    logic [31:0] rd_mux;

    // sample only while ack is low, so a held request is taken once
    assign new_req   = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
    assign is_reg    = !wb_req.adr[3];
    assign is_cmd    = (wb_req.adr == alu_pkg::adr_cmd);
    assign is_status = (wb_req.adr == alu_pkg::adr_status);
    assign cmd_wr    = new_req && wb_req.we && is_cmd;

    assign cmd = alu_pkg::alu_cmd_t'(wb_req.dat);

    // rd_a is shared: bus read index or rs1
    assign rd_a_idx = is_cmd ? cmd.rs1 : wb_req.adr[2:0];
    assign rd_b_idx = cmd.rs2;
    assign op       = cmd.op;

    // register file write port
    assign we      = new_req && wb_req.we && (is_reg || is_cmd);
    assign wr_idx  = is_cmd ? cmd.rd : wb_req.adr[2:0];
    assign wr_data = is_cmd ? alu_result : wb_req.dat;

    // read data select
    always_comb begin
        if (is_reg) begin
            rd_mux = rd_a_data;
        end else if (is_cmd) begin
            rd_mux = last_cmd;
        end else if (is_status) begin
            rd_mux = {31'd0, status_zero};
        end else begin
            rd_mux = 32'd0;     // unmapped
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_rsp.ack <= 1'b0;
            wb_rsp.dat <= 32'd0;
        end else begin
            wb_rsp.ack <= new_req;  // one cycle pulse
            if (new_req) begin
                wb_rsp.dat <= wb_req.we ? 32'd0 : rd_mux;
            end
        end
    end

    // status and last command move on the same edge as ack
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_zero <= 1'b0;
            last_cmd    <= '0;
        end else if (cmd_wr) begin
            status_zero <= alu_zero;
            last_cmd    <= cmd;
        end
    end

    // master keeps the request up until it sees ack
    a_req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        new_req |=> wb_req.cyc && wb_req.stb
    ) else $error("wb slave: request dropped before ack");

    a_cmd_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        cmd_wr |-> !$isunknown({alu_result, alu_zero})
    ) else $error("wb slave: unknown alu result on command");

endmodule

//--- alu_regfile.sv
module alu_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  alu_pkg::reg_idx_t rd_a_idx,
    input  alu_pkg::reg_idx_t rd_b_idx,
    output logic [31:0]       rd_a_data,
    output logic [31:0]       rd_b_data,
    input  logic              we,
    input  alu_pkg::reg_idx_t wr_idx,
    input  logic [31:0]       wr_data
);

    logic [31:0] regs [8];

    // single write port, registers come out of reset cleared
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // read during write sees the old value
    assign rd_a_data = regs[rd_a_idx];
    assign rd_b_data = regs[rd_b_idx];

    // an X on we would corrupt a random register
    a_we_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(we)
    ) else $error("regfile: write enable unknown");

endmodule

//--- alu.sv
module alu (
    input  logic [31:0]      a,
    input  logic [31:0]      b,
    input  alu_pkg::alu_op_e op,
    output logic [31:0]      result,
    output logic             zero
);

    logic [4:0] shamt;
    logic       op_defined;

    assign shamt = b[4:0];  // only low five bits shift

    always_comb begin
        result     = 32'd0;
        zero       = 1'b1;   // undefined op reads as zero result
        op_defined = 1'b1;
        case (op)
            alu_pkg::op_add: begin
                result = a + b;
            end
            alu_pkg::op_sub: begin
                result = a - b;
            end
            alu_pkg::op_and: begin
                result = a & b;
            end
            alu_pkg::op_or: begin
                result = a | b;
            end
            alu_pkg::op_xor: begin
                result = a ^ b;
            end
            alu_pkg::op_sll: begin
                result = a << shamt;
            end
            alu_pkg::op_srl: begin
                result = a >> shamt;
            end
            default: begin
                op_defined = 1'b0;
            end
        endcase

        if (op_defined) begin
            zero = (result == 32'd0);
        end
    end

endmodule

//--- alu_pkg.sv
package alu_pkg;

    // opcodes, 7..15 left undefined
    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_sll = 4'd5,
        op_srl = 4'd6
    } alu_op_e;

    typedef logic [2:0] reg_idx_t;

    // command word, rd = rs1 op rs2
    typedef struct packed {
        logic [18:0] reserved;
        alu_op_e     op;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
    } alu_cmd_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;   // word address
        logic [31:0] dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // address map
    // 0..7 are R0..R7, 10..15 read as zero
    localparam logic [3:0] adr_cmd    = 4'd8;
    localparam logic [3:0] adr_status = 4'd9;

endpackage
